/* source/huff_settings.svh */
`ifndef HUFF_SETTINGS_SVH
`define HUFF_SETTINGS_SVH

// node memory address width
`define HUFF_ADDR_W 8

// child entry width
// bit 8 set marks a sum and bits 7:0 hold the child node address
// bit 8 clear marks a char and bits 7:0 hold the char
`define HUFF_ENTRY_W 9

// entry code for a missing child
`define HUFF_NULL_ENTRY 9'b1_1000_0000

// longest code and deepest right-entry stack
`define HUFF_MAX_DEPTH 16

// code length width, must hold HUFF_MAX_DEPTH
`define HUFF_LEN_W 5

// output credits after reset, also the emitter queue depth
`define HUFF_CREDITS 4

`endif

/* source/huff_pkg.sv */
`include "huff_settings.svh"

package huff_pkg;

  // output credits and emitter queue depth
  localparam int CREDITS = `HUFF_CREDITS;

  // position of the sum flag inside a raw entry
  localparam int SUM_BIT = `HUFF_ENTRY_W - 1;

  typedef logic [`HUFF_ADDR_W-1:0] addr_t;
  typedef logic [7:0] char_t;
  typedef logic [`HUFF_ENTRY_W-1:0] raw_entry_t;
  // node word as stored, left entry in the upper half
  typedef logic [2*`HUFF_ENTRY_W-1:0] mem_word_t;
  typedef logic [`HUFF_MAX_DEPTH-1:0] bits_t;
  typedef logic [`HUFF_LEN_W-1:0] len_t;

  localparam raw_entry_t NULL_ENTRY = `HUFF_NULL_ENTRY;

  typedef enum logic [1:0] {
    ENTRY_CHAR,
    ENTRY_SUM,
    ENTRY_NONE
  } entry_kind_e;

  // decoded child entry, value is a char or a node address
  typedef struct packed {
    entry_kind_e kind;
    logic [SUM_BIT-1:0] value;
  } entry_t;

  typedef struct packed {
    entry_t left;
    entry_t right;
  } node_t;

  // bits are right aligned with the first branch on top
  typedef struct packed {
    char_t char;
    bits_t bits;
    len_t len;
  } code_t;

endpackage

/* source/node_if.sv */
// node fetch path between the decoder and the walker
interface node_if;

  // fetch request, one cycle wide
  logic req;
  huff_pkg::addr_t addr;

  // decoded node, one cycle wide, one per request
  logic valid;
  huff_pkg::node_t node;

  modport decode (
    input req,
    input addr,
    output valid,
    output node
  );

  modport walk (
    output req,
    output addr,
    input valid,
    input node
  );

endinterface

/* source/code_if.sv */
// finished codes from the walker into the emitter queue
interface code_if;

  // push is only raised while space is high
  logic push;
  huff_pkg::code_t code;

  // queue has room for one more code
  logic space;

  modport walk (
    output push,
    output code,
    input space
  );

  modport emit (
    input push,
    input code,
    output space
  );

endinterface

/* source/tree_decode.sv */
module tree_decode (
  input logic clk,
  input logic rst,
  node_if.decode nd,
  output logic mem_req,
  output huff_pkg::addr_t mem_addr,
  input logic mem_valid,
  input huff_pkg::mem_word_t mem_data
);

  // registered memory response
  logic valid_q;
  huff_pkg::mem_word_t word_q;

  // raw halves of the stored word
  huff_pkg::raw_entry_t raw_left;
  huff_pkg::raw_entry_t raw_right;

  // turn a raw entry into kind plus value
  function automatic huff_pkg::entry_t classify(input huff_pkg::raw_entry_t raw);
    huff_pkg::entry_t e;
    e.value = raw[huff_pkg::SUM_BIT-1:0];
    // null code has the sum bit set too, so test it first
    if (raw == huff_pkg::NULL_ENTRY) begin
      e.kind = huff_pkg::ENTRY_NONE;
    end else if (raw[huff_pkg::SUM_BIT]) begin
      e.kind = huff_pkg::ENTRY_SUM;
    end else begin
      e.kind = huff_pkg::ENTRY_CHAR;
    end
    return e;
  endfunction

  // requests go straight through to memory in the same cycle
  assign mem_req = nd.req;
  assign mem_addr = nd.addr;

  // response strobe delayed by one cycle
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= mem_valid;
    end
  end

  // capture the node word when it arrives
  always_ff @(posedge clk) begin
    if (mem_valid) begin
      word_q <= mem_data;
    end
  end

  // left entry sits in the upper half
  assign {raw_left, raw_right} = word_q;

  assign nd.valid = valid_q;
  assign nd.node.left = classify(raw_left);
  assign nd.node.right = classify(raw_right);

endmodule

/* source/tree_walk.sv */
`include "huff_settings.svh"

module tree_walk (
  input logic clk,
  input logic rst,
  input logic start,
  input huff_pkg::addr_t root_addr,
  node_if.walk nd,
  code_if.walk cq,
  output logic done
);

  // stack index width and entry count width
  localparam int SP_W = $clog2(`HUFF_MAX_DEPTH);
  localparam int CNT_W = $clog2(`HUFF_MAX_DEPTH + 1);

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    WAIT_NODE,
    LEFT,
    RIGHT,
    POP
  } state_e;

  // pending right entry and the depth of its parent node
  typedef struct packed {
    huff_pkg::entry_t entry;
    huff_pkg::len_t depth;
  } stack_item_t;

  state_e state;

  // path to the current node, right aligned, depth bits valid
  huff_pkg::bits_t path;
  huff_pkg::len_t depth;

  // entry under work in LEFT or RIGHT
  huff_pkg::entry_t cur;
  huff_pkg::addr_t root_q;

  // right-entry stack
  stack_item_t stack [`HUFF_MAX_DEPTH];
  logic [CNT_W-1:0] sp;
  logic [SP_W-1:0] push_idx;
  logic [SP_W-1:0] top_idx;
  stack_item_t top;
  logic push_right;

  // one step down from the current node
  logic branch;
  logic handling;
  huff_pkg::bits_t new_path;
  huff_pkg::len_t new_depth;

  assign push_idx = SP_W'(sp);
  assign top_idx = SP_W'(sp - 1'b1);
  assign top = stack[top_idx];

  // null right children never go on the stack
  assign push_right = (nd.node.right.kind != huff_pkg::ENTRY_NONE);

  // left branch is 0, right branch is 1
  assign branch = (state == RIGHT);
  assign handling = (state == LEFT) || (state == RIGHT);
  assign new_path = {path[`HUFF_MAX_DEPTH-2:0], branch};
  assign new_depth = depth + 1'b1;

  // fetch requests and code pushes
  always_comb begin
    nd.req = 1'b0;
    nd.addr = root_q;
    cq.push = 1'b0;
    cq.code.char = cur.value;
    cq.code.bits = new_path;
    cq.code.len = new_depth;
    if (state == FETCH) begin
      // root fetch
      nd.req = 1'b1;
    end else if (handling) begin
      case (cur.kind)
        huff_pkg::ENTRY_SUM: begin
          // descend straight away, no extra fetch cycle
          nd.req = 1'b1;
          nd.addr = huff_pkg::addr_t'(cur.value);
        end
        huff_pkg::ENTRY_CHAR: begin
          // leaf found, wait here while the queue is full
          cq.push = cq.space;
        end
        default: begin
          nd.req = 1'b0;
        end
      endcase
    end
  end

  // traversal control
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= IDLE;
      path <= '0;
      depth <= '0;
      sp <= '0;
      done <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            path <= '0;
            depth <= '0;
            sp <= '0;
            done <= 1'b0;
            state <= FETCH;
          end
        end
        FETCH: begin
          state <= WAIT_NODE;
        end
        WAIT_NODE: begin
          if (nd.valid) begin
            if (push_right) begin
              sp <= sp + 1'b1;
            end
            state <= LEFT;
          end
        end
        LEFT, RIGHT: begin
          case (cur.kind)
            huff_pkg::ENTRY_SUM: begin
              path <= new_path;
              depth <= new_depth;
              state <= WAIT_NODE;
            end
            huff_pkg::ENTRY_CHAR: begin
              if (cq.space) begin
                state <= POP;
              end
            end
            default: begin
              state <= POP;
            end
          endcase
        end
        POP: begin
          if (sp == '0) begin
            // nothing pending, walk is over
            done <= 1'b1;
            state <= IDLE;
          end else begin
            // climb back to the parent of the popped entry
            sp <= sp - 1'b1;
            depth <= top.depth;
            path <= path >> (depth - top.depth);
            state <= RIGHT;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // root address, entry under work and stack contents
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      root_q <= root_addr;
    end
    if (state == WAIT_NODE && nd.valid) begin
      cur <= nd.node.left;
      if (push_right) begin
        stack[push_idx] <= '{entry: nd.node.right, depth: depth};
      end
    end
    if (state == POP && sp != '0) begin
      cur <= top.entry;
    end
  end

endmodule

/* source/code_emit.sv */
module code_emit (
  input logic clk,
  input logic rst,
  code_if.emit cq,
  output logic code_valid,
  output huff_pkg::char_t code_char,
  output huff_pkg::bits_t code_bits,
  output huff_pkg::len_t code_len,
  input logic code_credit
);

  // queue depth matches the credit count
  localparam int DEPTH = huff_pkg::CREDITS;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  huff_pkg::code_t queue [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] credits;
  logic pop;
  huff_pkg::code_t head;

  // pointer step with wrap for any depth
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign cq.space = (count != CNT_W'(DEPTH));

  // head leaves whenever a credit is available
  assign pop = (count != '0) && (credits != '0);
  assign head = queue[rd_ptr];

  assign code_valid = pop;
  assign code_char = head.char;
  assign code_bits = head.bits;
  assign code_len = head.len;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credits <= CNT_W'(DEPTH);
    end else begin
      if (cq.push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      // fill level
      case ({cq.push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
      // spent and returned in the same cycle cancel out
      case ({pop, code_credit})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cq.push) begin
      queue[wr_ptr] <= cq.code;
    end
  end

endmodule

/* source/codebook_gen.sv */
module codebook_gen (
  input logic clk,
  input logic rst,
  input logic start,
  input huff_pkg::addr_t root_addr,
  output logic mem_req,
  output huff_pkg::addr_t mem_addr,
  input logic mem_valid,
  input huff_pkg::mem_word_t mem_data,
  output logic code_valid,
  output huff_pkg::char_t code_char,
  output huff_pkg::bits_t code_bits,
  output huff_pkg::len_t code_len,
  input logic code_credit,
  output logic done
);

  // node fetch path and code path
  node_if nd ();
  code_if cq ();

  // memory side, word split and entry classification
  tree_decode u_decode (
    .clk (clk),
    .rst (rst),
    .nd (nd.decode),
    .mem_req (mem_req),
    .mem_addr (mem_addr),
    .mem_valid (mem_valid),
    .mem_data (mem_data)
  );

  // depth-first traversal
  tree_walk u_walk (
    .clk (clk),
    .rst (rst),
    .start (start),
    .root_addr (root_addr),
    .nd (nd.walk),
    .cq (cq.walk),
    .done (done)
  );

  // code queue and credit-based output
  code_emit u_emit (
    .clk (clk),
    .rst (rst),
    .cq (cq.emit),
    .code_valid (code_valid),
    .code_char (code_char),
    .code_bits (code_bits),
    .code_len (code_len),
    .code_credit (code_credit)
  );

endmodule

/* test/tb_tree_mem.sv */
// node memory model for the codebook testbench
// answers one request at a time after a random latency of 1 to 4 cycles
module tb_tree_mem (
  input logic clk,
  input logic rst,
  input logic mem_req,
  input huff_pkg::addr_t mem_addr,
  output logic mem_valid,
  output huff_pkg::mem_word_t mem_data
);
  timeunit 1ns;
  timeprecision 100ps;

  // node words, written by the testbench before each walk
  huff_pkg::mem_word_t words [256];

  // latency source
  integer seed = 69;

  // pending request
  logic busy = 1'b0;
  int wait_cnt = 0;
  huff_pkg::addr_t addr_q;

  initial begin
    mem_valid = 1'b0;
    mem_data = '0;
    forever begin
      // responses change shortly after the rising edge
      @(posedge clk);
      #1;
      mem_valid = 1'b0;
      if (rst) begin
        busy = 1'b0;
      end else begin
        if (busy) begin
          wait_cnt = wait_cnt - 1;
          if (wait_cnt == 0) begin
            mem_valid = 1'b1;
            mem_data = words[addr_q];
            busy = 1'b0;
          end
        end
        // a request seen now is answered 1 to 4 cycles later
        if (mem_req) begin
          addr_q = mem_addr;
          wait_cnt = 1 + ($random(seed) & 3);
          busy = 1'b1;
        end
      end
    end
  end

endmodule

/* test/codebook_tb.sv */
// testbench for the huffman codebook generator
module codebook_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // 20 random trees plus the two null-child trees
  localparam int NUM_TESTS = 22;
  localparam int STEP_LIMIT = 2000;

  // extra credit delay on slow trees, long enough to drain all credits and fill the queue
  localparam int SLOW_HOLD = 40;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic start = 1'b0;
  huff_pkg::addr_t root_addr = '0;
  logic mem_req;
  huff_pkg::addr_t mem_addr;
  logic mem_valid;
  huff_pkg::mem_word_t mem_data;
  logic code_valid;
  huff_pkg::char_t code_char;
  huff_pkg::bits_t code_bits;
  huff_pkg::len_t code_len;
  logic code_credit = 1'b0;
  logic done;

  integer seed = 69;
  int errors = 0;
  string test_name = "reset";

  // tree image and the codes the model expects from it
  huff_pkg::mem_word_t tree_words [256];
  int next_addr;
  huff_pkg::code_t expected[$];
  huff_pkg::code_t seen_code;
  int got = 0;

  // credit bookkeeping, due_q holds the cycle each credit goes back
  int emitted = 0;
  int returned = 0;
  int cycle = 0;
  int due_q[$];
  int credit_hold = 0;

  codebook_gen uut (
    .clk (clk),
    .rst (rst),
    .start (start),
    .root_addr (root_addr),
    .mem_req (mem_req),
    .mem_addr (mem_addr),
    .mem_valid (mem_valid),
    .mem_data (mem_data),
    .code_valid (code_valid),
    .code_char (code_char),
    .code_bits (code_bits),
    .code_len (code_len),
    .code_credit (code_credit),
    .done (done)
  );

  tb_tree_mem mem (
    .clk (clk),
    .rst (rst),
    .mem_req (mem_req),
    .mem_addr (mem_addr),
    .mem_valid (mem_valid),
    .mem_data (mem_data)
  );

  always #4 clk = ~clk;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic check_code(input string name, input huff_pkg::code_t exp,
                            input huff_pkg::code_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected char %02h bits %b len %0d, actual char %02h bits %b len %0d",
               name, exp.char, exp.bits, exp.len, act.char, act.bits, act.len);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // unused words get an address-dependent pattern
  task automatic clear_tree(input int base);
    for (int a = 0; a < 256; a++) begin
      tree_words[a] = {1'b0, 8'(a), 1'b0, ~8'(a)};
    end
    next_addr = base;
  endtask

  task automatic add_node(input huff_pkg::raw_entry_t left, input huff_pkg::raw_entry_t right,
                          output huff_pkg::addr_t addr);
    tree_words[next_addr] = {left, right};
    addr = huff_pkg::addr_t'(next_addr);
    next_addr = next_addr + 1;
  endtask

  // random shape by merging random pairs of a leaf pool
  // addresses stay below 0x80 so no sum entry looks like the null code
  task automatic build_random_tree(output huff_pkg::addr_t root);
    huff_pkg::raw_entry_t pool[$];
    huff_pkg::raw_entry_t left;
    huff_pkg::raw_entry_t right;
    int leaves;
    int i;
    leaves = 1 + rand_below(12);
    clear_tree(rand_below(64));
    for (i = 0; i < leaves; i++) begin
      pool.push_back({1'b0, 8'(rand_below(256))});
    end
    if (leaves == 1) begin
      add_node(pool[0], huff_pkg::NULL_ENTRY, root);
    end else begin
      while (pool.size() > 1) begin
        i = rand_below(pool.size());
        left = pool[i];
        pool.delete(i);
        i = rand_below(pool.size());
        right = pool[i];
        pool.delete(i);
        add_node(left, right, root);
        pool.push_back({1'b1, root});
      end
    end
  endtask

  // reference walk, depth first and left before right, nulls skipped
  task automatic build_expected(input huff_pkg::addr_t root);
    huff_pkg::raw_entry_t ent_q[$];
    huff_pkg::bits_t bits_q[$];
    huff_pkg::len_t len_q[$];
    huff_pkg::raw_entry_t ent;
    huff_pkg::bits_t bits;
    huff_pkg::len_t len;
    huff_pkg::code_t c;
    expected.delete();
    // right goes in first so left comes out first
    ent_q.push_back(tree_words[root][8:0]);
    bits_q.push_back(huff_pkg::bits_t'(1));
    len_q.push_back(huff_pkg::len_t'(1));
    ent_q.push_back(tree_words[root][17:9]);
    bits_q.push_back(huff_pkg::bits_t'(0));
    len_q.push_back(huff_pkg::len_t'(1));
    while (ent_q.size() != 0) begin
      ent = ent_q.pop_back();
      bits = bits_q.pop_back();
      len = len_q.pop_back();
      if (ent == huff_pkg::NULL_ENTRY) begin
        continue;
      end
      if (ent[8]) begin
        ent_q.push_back(tree_words[ent[7:0]][8:0]);
        bits_q.push_back({bits[14:0], 1'b1});
        len_q.push_back(len + 5'd1);
        ent_q.push_back(tree_words[ent[7:0]][17:9]);
        bits_q.push_back({bits[14:0], 1'b0});
        len_q.push_back(len + 5'd1);
      end else begin
        c.char = ent[7:0];
        c.bits = bits;
        c.len = len;
        expected.push_back(c);
      end
    end
  endtask

  // loads the tree, starts the walk and waits for done and the drain
  task automatic run_tree(input string name, input huff_pkg::addr_t root);
    int waited;
    test_name = name;
    for (int a = 0; a < 256; a++) begin
      mem.words[a] = tree_words[a];
    end
    build_expected(root);
    got = 0;
    root_addr = root;
    start = 1'b1;
    @(posedge clk);
    #1;
    start = 1'b0;
    waited = 0;
    while (done !== 1'b1 && waited < STEP_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (done !== 1'b1) begin
      errors++;
      $display("%s: done did not rise after %0d cycles", name, STEP_LIMIT);
    end
    // all codes are pushed by now, wait for them and their credits
    while ((got < expected.size() || due_q.size() != 0) && waited < STEP_LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    repeat (2) @(posedge clk);
    #1;
    check_count({name, " code count"}, expected.size(), got);
  endtask

  // output monitor, outputs are settled at the falling edge
  always @(negedge clk) begin
    if (!rst && code_valid === 1'b1) begin
      seen_code.char = code_char;
      seen_code.bits = code_bits;
      seen_code.len = code_len;
      emitted++;
      // a credit returned in this cycle is only usable from the next one
      if (emitted - returned + int'(code_credit) > huff_pkg::CREDITS) begin
        errors++;
        $display("%s: credit overrun, %0d codes outstanding", test_name,
                 emitted - returned + int'(code_credit));
      end
      if (got >= expected.size()) begin
        errors++;
        $display("%s: unexpected extra code for char %02h", test_name, code_char);
      end else begin
        check_code(test_name, expected[got], seen_code);
      end
      got++;
      due_q.push_back(cycle + credit_hold + rand_below(6));
    end
  end

  // credit return, at most one pulse per cycle
  always @(posedge clk) begin
    #1;
    cycle++;
    code_credit = 1'b0;
    if (due_q.size() != 0 && due_q[0] <= cycle) begin
      void'(due_q.pop_front());
      code_credit = 1'b1;
      returned++;
    end
  end

  // watchdog
  initial begin
    #(NUM_TESTS * STEP_LIMIT * 8);
    $display("watchdog expired before the tests finished");
    $display("sim failed");
    $finish;
  end

  initial begin
    huff_pkg::addr_t root;
    huff_pkg::code_t lone_code;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    // idle outputs before any start
    check_count("idle after reset", 0, int'({mem_req, code_valid, done}));
    for (int t = 0; t < 20; t++) begin
      // every other tree gets slow credits, so the queue fills and the walk stalls
      credit_hold = (t % 2 == 1) ? SLOW_HOLD : 0;
      build_random_tree(root);
      run_tree($sformatf("random tree %0d", t), root);
    end
    credit_hold = 0;
    // one char on the left and no right child
    clear_tree(90);
    add_node({1'b0, 8'h41}, huff_pkg::NULL_ENTRY, root);
    run_tree("single leaf", root);
    // the lone leaf sits one left branch below the root
    lone_code.char = 8'h41;
    lone_code.bits = '0;
    lone_code.len = 5'd1;
    check_code("single leaf code", lone_code, seen_code);
    // root without children
    clear_tree(17);
    add_node(huff_pkg::NULL_ENTRY, huff_pkg::NULL_ENTRY, root);
    run_tree("empty root", root);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+source
source/huff_pkg.sv
source/node_if.sv
source/code_if.sv
source/tree_decode.sv
source/tree_walk.sv
source/code_emit.sv
source/codebook_gen.sv
test/tb_tree_mem.sv
test/codebook_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the codebook generator testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  --top-module codebook_tb -f verilog.f -o codebook_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/codebook_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the fail message on any failure
if grep -q "sim failed" "$log"; then
  exit 1
fi
exit 0
